// ==== Bender.yml ====
package:
  name: kernel_bridge

sources:
  - logic/kernel_axi_pkg.sv
  - logic/kernel_host_pkg.sv
  - logic/queue_fifo.sv
  - logic/axi_write_port.sv
  - logic/nvme_cmd_builder.sv
  - logic/host_regs.sv
  - logic/kernel_top.sv
  - target: test
    files:
      - tests/kernel_tb.sv

// ==== all.f ====
logic/kernel_axi_pkg.sv
logic/kernel_host_pkg.sv
logic/queue_fifo.sv
logic/axi_write_port.sv
logic/nvme_cmd_builder.sv
logic/host_regs.sv
logic/kernel_top.sv
tests/kernel_tb.sv

// ==== logic/axi_write_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_port #(
  parameter int AXI_Q_DEPTH = 8
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  aw_push,
  input  logic                                  w_push,
  input  kernel_axi_pkg::stage_u                stage,
  input  logic                                  b_pop,
  output logic                                  b_valid,
  output kernel_axi_pkg::b_entry_t              b_entry,
  output logic [kernel_axi_pkg::AXI_ADDR_W-1:0] awaddr,
  output logic [kernel_axi_pkg::AXI_SIZE_W-1:0] awsize,
  output logic [1:0]                            awburst,
  output logic [kernel_axi_pkg::AXI_ID_W-1:0]   awid,
  output logic [kernel_axi_pkg::AXI_LEN_W-1:0]  awlen,
  output logic                                  awvalid,
  input  logic                                  awready,
  output logic [kernel_axi_pkg::AXI_DATA_W-1:0] wdata,
  output logic [kernel_axi_pkg::AXI_STRB_W-1:0] wstrb,
  output logic                                  wlast,
  output logic                                  wvalid,
  input  logic                                  wready,
  input  logic [kernel_axi_pkg::AXI_ID_W-1:0]   bid,
  input  logic [kernel_axi_pkg::AXI_RESP_W-1:0] bresp,
  input  logic                                  bvalid,
  output logic                                  bready
);

  import kernel_axi_pkg::*;

  localparam int AW_Q_W = AXI_SIZE_W + AXI_ADDR_W;
  localparam int W_Q_W  = AXI_STRB_W + AXI_DATA_W;
  localparam int B_Q_W  = AXI_ID_W + AXI_RESP_W;

  logic [AW_Q_W-1:0] aw_q_rdata;
  logic [W_Q_W-1:0]  w_q_rdata;
  logic [B_Q_W-1:0]  b_q_rdata;

  queue_fifo #(.WIDTH(AW_Q_W), .DEPTH(AXI_Q_DEPTH)) i_aw_q (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (aw_push),
    .wdata  ({stage.aw.size, stage.aw.addr}),
    .wready (),
    .rvalid (awvalid),
    .rdata  (aw_q_rdata),
    .rready (awready)
  );

  queue_fifo #(.WIDTH(W_Q_W), .DEPTH(AXI_Q_DEPTH)) i_w_q (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (w_push),
    .wdata  ({stage.w.strb, stage.w.data}),
    .wready (),
    .rvalid (wvalid),
    .rdata  (w_q_rdata),
    .rready (wready)
  );

  queue_fifo #(.WIDTH(B_Q_W), .DEPTH(AXI_Q_DEPTH)) i_b_q (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (bvalid),
    .wdata  ({bid, bresp}),
    .wready (bready), // stall responses only when full
    .rvalid (b_valid),
    .rdata  (b_q_rdata),
    .rready (b_pop)
  );

  assign {awsize, awaddr} = aw_q_rdata;
  assign {wstrb, wdata}   = w_q_rdata;
  assign awburst = AXI_BURST_INCR;
  assign awid    = AXI_AW_ID;
  assign awlen   = '0; // single beat bursts
  assign wlast   = 1'b1;

  always_comb begin
    b_entry = '0;
    {b_entry.id, b_entry.resp} = b_q_rdata;
  end

endmodule

`default_nettype wire

// ==== logic/host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_regs (
  input  logic                                      clk,
  input  logic                                      rstn,
  input  logic [kernel_host_pkg::HOST_ADDR_W-1:0]   host_addr,
  input  logic [kernel_host_pkg::HOST_DATA_W-1:0]   host_din,
  input  logic                                      host_en,
  input  logic [kernel_host_pkg::HOST_DATA_W/8-1:0] host_we,
  output logic [kernel_host_pkg::HOST_DATA_W-1:0]   host_dout,
  output logic                                      aw_push,
  output logic                                      w_push,
  output logic                                      b_pop,
  output kernel_axi_pkg::stage_u                    stage,
  input  logic                                      b_valid,
  input  kernel_axi_pkg::b_entry_t                  b_entry,
  output logic [kernel_host_pkg::HOST_DATA_W-1:0]   cmd_din,
  output logic                                      lba_we,
  output logic                                      dptr_we,
  output logic                                      ctrl_we,
  output logic                                      submit,
  output logic                                      sq_pop,
  input  logic                                      sq_valid,
  input  logic [kernel_host_pkg::CMD_W-1:0]         sq_head,
  input  logic [kernel_host_pkg::CID_W-1:0]         command_id,
  input  logic [kernel_host_pkg::CID_W-1:0]         head_ptr
);

  import kernel_axi_pkg::*;
  import kernel_host_pkg::*;

  localparam int WIN_W = $clog2(CMD_W / HOST_DATA_W);

  logic                   wr_cyc;
  logic                   rd_cyc;
  logic                   stage_hit;
  logic [2:0]             stage_idx;
  logic [HOST_ADDR_W-1:0] win_off;
  logic                   win_hit;
  logic [WIN_W-1:0]       win_idx;
  logic                   rd_hit;
  logic [HOST_DATA_W-1:0] rd_data;

  assign wr_cyc    = host_en && (host_we != '0);
  assign rd_cyc    = host_en && (host_we == '0);
  assign stage_idx = host_addr[4:2];
  assign win_off   = host_addr - REG_SQ_ENTRY;
  assign win_hit   = (host_addr >= REG_SQ_ENTRY) && (win_off < HOST_ADDR_W'(CMD_W / 8));
  assign win_idx   = win_off[WIN_W+1:2];

  always_comb begin
    case (host_addr)
      REG_STAGE0, REG_STAGE1, REG_STAGE2, REG_STAGE3,
      REG_STAGE4, REG_STAGE5, REG_STAGE6, REG_STAGE7: stage_hit = 1'b1;
      default: stage_hit = 1'b0;
    endcase
  end

  // read select, unmapped reads leave host_dout alone
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    if (stage_hit) begin
      rd_data = stage[stage_idx*HOST_DATA_W +: HOST_DATA_W];
    end else if (host_addr == REG_B_STATUS) begin
      rd_data = HOST_DATA_W'(b_valid);
    end else if (host_addr == REG_SQ_DOORBELL) begin
      rd_data = sq_head[CMD_DW_CDW0*HOST_DATA_W +: HOST_DATA_W];
    end else if (host_addr == REG_SQ_PTRS) begin
      rd_data = {command_id, head_ptr};
    end else if (win_hit) begin
      rd_data = sq_head[win_idx*HOST_DATA_W +: HOST_DATA_W];
    end else begin
      rd_hit = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push   <= 1'b0;
      w_push    <= 1'b0;
      b_pop     <= 1'b0;
      lba_we    <= 1'b0;
      dptr_we   <= 1'b0;
      ctrl_we   <= 1'b0;
      submit    <= 1'b0;
      sq_pop    <= 1'b0;
      host_dout <= '0;
    end else begin
      aw_push <= wr_cyc && (host_addr == REG_AW_PUSH);
      w_push  <= wr_cyc && (host_addr == REG_W_PUSH);
      b_pop   <= wr_cyc && (host_addr == REG_B_POP);
      lba_we  <= wr_cyc && (host_addr == REG_CMD_LBA);
      dptr_we <= wr_cyc && (host_addr == REG_CMD_DPTR);
      ctrl_we <= wr_cyc && (host_addr == REG_CMD_CTRL);
      submit  <= wr_cyc && (host_addr == REG_SQ_DOORBELL);
      sq_pop  <= rd_cyc && (host_addr == REG_SQ_DOORBELL) && sq_valid;
      if (rd_cyc && rd_hit) begin
        host_dout <= rd_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_cyc) begin
      cmd_din <= host_din; // lines up with the command strobes
    end
    if (wr_cyc && stage_hit) begin
      stage[stage_idx*HOST_DATA_W +: HOST_DATA_W] <= host_din;
    end else if (wr_cyc && (host_addr == REG_B_POP) && b_valid) begin
      stage.b <= b_entry; // head response, popped next cycle
    end
  end

endmodule

`default_nettype wire

// ==== logic/kernel_axi_pkg.sv ====
`default_nettype none

package kernel_axi_pkg;

  localparam int AXI_ADDR_W = 64;
  localparam int AXI_DATA_W = 128;
  localparam int AXI_STRB_W = 16;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_SIZE_W = 3;
  localparam int AXI_RESP_W = 2;
  localparam int AXI_LEN_W  = 8;

  localparam logic [1:0]          AXI_BURST_INCR = 2'd1;
  localparam logic [AXI_ID_W-1:0] AXI_AW_ID      = 4'd1; // id of every write burst

  localparam int STAGE_W = 256;

  typedef struct packed {
    logic [STAGE_W-AXI_SIZE_W-AXI_ADDR_W-1:0] rsvd;
    logic [AXI_SIZE_W-1:0]                    size;
    logic [AXI_ADDR_W-1:0]                    addr; // dwords 0 and 1
  } aw_entry_t;

  typedef struct packed {
    logic [STAGE_W-AXI_STRB_W-AXI_DATA_W-1:0] rsvd;
    logic [AXI_STRB_W-1:0]                    strb; // dword 4, low half
    logic [AXI_DATA_W-1:0]                    data;
  } w_entry_t;

  typedef struct packed {
    logic [STAGE_W-AXI_ID_W-AXI_RESP_W-1:0] rsvd;
    logic [AXI_ID_W-1:0]                    id;
    logic [AXI_RESP_W-1:0]                  resp; // bits 1:0 of dword 0
  } b_entry_t;

  // one staging word, three views
  typedef union packed {
    aw_entry_t aw;
    w_entry_t  w;
    b_entry_t  b;
  } stage_u;

endpackage

`default_nettype wire

// ==== logic/kernel_host_pkg.sv ====
`default_nettype none

package kernel_host_pkg;

  localparam int HOST_ADDR_W = 15;
  localparam int HOST_DATA_W = 32;

  // staging word, one dword each
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE0 = 15'h000;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE1 = 15'h004;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE2 = 15'h008;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE3 = 15'h00C;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE4 = 15'h010;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE5 = 15'h014;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE6 = 15'h018;
  localparam logic [HOST_ADDR_W-1:0] REG_STAGE7 = 15'h01C;

  localparam logic [HOST_ADDR_W-1:0] REG_AW_PUSH  = 15'h020;
  localparam logic [HOST_ADDR_W-1:0] REG_W_PUSH   = 15'h030;
  localparam logic [HOST_ADDR_W-1:0] REG_B_STATUS = 15'h050;
  localparam logic [HOST_ADDR_W-1:0] REG_B_POP    = 15'h054;

  localparam logic [HOST_ADDR_W-1:0] REG_CMD_LBA     = 15'h100;
  localparam logic [HOST_ADDR_W-1:0] REG_CMD_DPTR    = 15'h104;
  localparam logic [HOST_ADDR_W-1:0] REG_CMD_CTRL    = 15'h108;
  localparam logic [HOST_ADDR_W-1:0] REG_SQ_DOORBELL = 15'h110; // write submits, read pops
  localparam logic [HOST_ADDR_W-1:0] REG_SQ_PTRS     = 15'h114;
  localparam logic [HOST_ADDR_W-1:0] REG_SQ_ENTRY    = 15'h120; // sixteen dwords of the head entry

  // nvme submission entry
  localparam int CMD_W       = 512;
  localparam int CMD_DW_CDW0 = 0;
  localparam int CMD_DW_NSID = 1;
  localparam int CMD_DW_DPTR = 6;
  localparam int CMD_DW_LBA  = 10;

  localparam logic [HOST_DATA_W-1:0] CMD_NSID_VALUE = 32'd1;

  localparam int CID_W = 16;

endpackage

`default_nettype wire

// ==== logic/kernel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_top #(
  parameter int AXI_Q_DEPTH = 8,
  parameter int SQ_DEPTH    = 4
) (
  input  logic                                      clk,
  input  logic                                      rstn,
  input  logic [kernel_host_pkg::HOST_ADDR_W-1:0]   host_addr,
  input  logic [kernel_host_pkg::HOST_DATA_W-1:0]   host_din,
  output logic [kernel_host_pkg::HOST_DATA_W-1:0]   host_dout,
  input  logic                                      host_en,
  input  logic [kernel_host_pkg::HOST_DATA_W/8-1:0] host_we,
  output logic [kernel_axi_pkg::AXI_ADDR_W-1:0]     awaddr,
  output logic [kernel_axi_pkg::AXI_SIZE_W-1:0]     awsize,
  output logic [1:0]                                awburst,
  output logic [kernel_axi_pkg::AXI_ID_W-1:0]       awid,
  output logic [kernel_axi_pkg::AXI_LEN_W-1:0]      awlen,
  output logic                                      awvalid,
  input  logic                                      awready,
  output logic [kernel_axi_pkg::AXI_DATA_W-1:0]     wdata,
  output logic [kernel_axi_pkg::AXI_STRB_W-1:0]     wstrb,
  output logic                                      wlast,
  output logic                                      wvalid,
  input  logic                                      wready,
  input  logic [kernel_axi_pkg::AXI_ID_W-1:0]       bid,
  input  logic [kernel_axi_pkg::AXI_RESP_W-1:0]     bresp,
  input  logic                                      bvalid,
  output logic                                      bready
);

  import kernel_axi_pkg::*;
  import kernel_host_pkg::*;

  logic                   aw_push;
  logic                   w_push;
  logic                   b_pop;
  stage_u                 stage;
  logic                   b_valid;
  b_entry_t               b_entry;
  logic [HOST_DATA_W-1:0] cmd_din;
  logic                   lba_we;
  logic                   dptr_we;
  logic                   ctrl_we;
  logic                   submit;
  logic                   sq_pop;
  logic                   sq_valid;
  logic [CMD_W-1:0]       sq_head;
  logic [CID_W-1:0]       command_id;
  logic [CID_W-1:0]       head_ptr;

  host_regs i_host_regs (
    .clk        (clk),
    .rstn       (rstn),
    .host_addr  (host_addr),
    .host_din   (host_din),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_dout  (host_dout),
    .aw_push    (aw_push),
    .w_push     (w_push),
    .b_pop      (b_pop),
    .stage      (stage),
    .b_valid    (b_valid),
    .b_entry    (b_entry),
    .cmd_din    (cmd_din),
    .lba_we     (lba_we),
    .dptr_we    (dptr_we),
    .ctrl_we    (ctrl_we),
    .submit     (submit),
    .sq_pop     (sq_pop),
    .sq_valid   (sq_valid),
    .sq_head    (sq_head),
    .command_id (command_id),
    .head_ptr   (head_ptr)
  );

  axi_write_port #(.AXI_Q_DEPTH(AXI_Q_DEPTH)) i_axi_write_port (
    .clk     (clk),
    .rstn    (rstn),
    .aw_push (aw_push),
    .w_push  (w_push),
    .stage   (stage),
    .b_pop   (b_pop),
    .b_valid (b_valid),
    .b_entry (b_entry),
    .awaddr  (awaddr),
    .awsize  (awsize),
    .awburst (awburst),
    .awid    (awid),
    .awlen   (awlen),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  nvme_cmd_builder #(.SQ_DEPTH(SQ_DEPTH)) i_nvme_cmd_builder (
    .clk        (clk),
    .rstn       (rstn),
    .cmd_din    (cmd_din),
    .lba_we     (lba_we),
    .dptr_we    (dptr_we),
    .ctrl_we    (ctrl_we),
    .submit     (submit),
    .sq_pop     (sq_pop),
    .sq_valid   (sq_valid),
    .sq_head    (sq_head),
    .command_id (command_id),
    .head_ptr   (head_ptr)
  );

endmodule

`default_nettype wire

// ==== logic/nvme_cmd_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module nvme_cmd_builder #(
  parameter int SQ_DEPTH = 4
) (
  input  logic                                    clk,
  input  logic                                    rstn,
  input  logic [kernel_host_pkg::HOST_DATA_W-1:0] cmd_din,
  input  logic                                    lba_we,
  input  logic                                    dptr_we,
  input  logic                                    ctrl_we,
  input  logic                                    submit,
  input  logic                                    sq_pop,
  output logic                                    sq_valid,
  output logic [kernel_host_pkg::CMD_W-1:0]       sq_head,
  output logic [kernel_host_pkg::CID_W-1:0]       command_id,
  output logic [kernel_host_pkg::CID_W-1:0]       head_ptr
);

  import kernel_host_pkg::*;

  logic [HOST_DATA_W-1:0] cdw0;
  logic [HOST_DATA_W-1:0] dptr;
  logic [HOST_DATA_W-1:0] lba;
  logic [CMD_W-1:0]       command;
  logic                   sq_ready;

  always_ff @(posedge clk) begin
    if (lba_we) begin
      lba <= cmd_din;
    end
    if (dptr_we) begin
      dptr <= cmd_din;
    end
    if (ctrl_we) begin
      lba[31:16] <= cmd_din[31:16]; // nlb
      cdw0       <= {command_id, 8'h00, cmd_din[7:0]}; // cid and opcode
    end
  end

  always_comb begin
    command = '0;
    command[CMD_DW_CDW0*HOST_DATA_W +: HOST_DATA_W] = cdw0;
    command[CMD_DW_NSID*HOST_DATA_W +: HOST_DATA_W] = CMD_NSID_VALUE;
    command[CMD_DW_DPTR*HOST_DATA_W +: HOST_DATA_W] = dptr;
    command[CMD_DW_LBA*HOST_DATA_W +: HOST_DATA_W]  = lba;
  end

  // counters move only on an accepted submit
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      command_id <= '0;
      head_ptr   <= '0;
    end else if (submit && sq_ready) begin
      command_id <= command_id + 1'b1;
      head_ptr   <= head_ptr + 1'b1;
    end
  end

  queue_fifo #(.WIDTH(CMD_W), .DEPTH(SQ_DEPTH)) i_sq (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (submit),
    .wdata  (command),
    .wready (sq_ready),
    .rvalid (sq_valid),
    .rdata  (sq_head),
    .rready (sq_pop)
  );

endmodule

`default_nettype wire

// ==== logic/queue_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module queue_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             wvalid,
  input  logic [WIDTH-1:0] wdata,
  output logic             wready,
  output logic             rvalid,
  output logic [WIDTH-1:0] rdata,
  input  logic             rready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign wready = (count != CNT_W'(DEPTH));
  assign rvalid = (count != '0);
  assign rdata  = mem[rd_ptr]; // head slot falls through
  assign push   = wvalid && wready;
  assign pop    = rvalid && rready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tests/kernel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_tb;

  import kernel_axi_pkg::*;
  import kernel_host_pkg::*;

  localparam int AXI_Q_DEPTH = 8;
  localparam int SQ_DEPTH    = 4;
  localparam int N_BEATS     = 3;
  localparam int N_STIM      = 10;
  localparam int N_REC       = 16;
  localparam int TIMEOUT     = 200; // cycles per wait

  typedef struct packed {
    logic [HOST_ADDR_W-1:0] off;
    logic [HOST_DATA_W-1:0] data;
    logic [HOST_DATA_W-1:0] exp;
  } stim_t;

  logic                   clk;
  logic                   rstn;
  logic [HOST_ADDR_W-1:0] host_addr;
  logic [HOST_DATA_W-1:0] host_din;
  logic [HOST_DATA_W-1:0] host_dout;
  logic                   host_en;
  logic [3:0]             host_we;
  logic [AXI_ADDR_W-1:0]  awaddr;
  logic [AXI_SIZE_W-1:0]  awsize;
  logic [1:0]             awburst;
  logic [AXI_ID_W-1:0]    awid;
  logic [AXI_LEN_W-1:0]   awlen;
  logic                   awvalid;
  logic                   awready;
  logic [AXI_DATA_W-1:0]  wdata;
  logic [AXI_STRB_W-1:0]  wstrb;
  logic                   wlast;
  logic                   wvalid;
  logic                   wready;
  logic [AXI_ID_W-1:0]    bid;
  logic [AXI_RESP_W-1:0]  bresp;
  logic                   bvalid;
  logic                   bready;

  logic [AXI_ADDR_W-1:0]  got_awaddr [N_REC];
  logic [AXI_SIZE_W-1:0]  got_awsize [N_REC];
  logic [AXI_DATA_W-1:0]  got_wdata [N_REC];
  logic [AXI_STRB_W-1:0]  got_wstrb [N_REC];
  logic [AXI_ADDR_W-1:0]  exp_awaddr [N_BEATS];
  logic [AXI_SIZE_W-1:0]  exp_awsize [N_BEATS];
  logic [AXI_DATA_W-1:0]  exp_wdata [N_BEATS];
  logic [AXI_STRB_W-1:0]  exp_wstrb [N_BEATS];
  int                     aw_count;
  int                     w_count;
  logic [31:0]            stage_words [8];
  stim_t                  stim_tbl [N_STIM];
  logic [31:0]            lcg_state;
  int                     mismatch_count;
  int                     timeout_count;

  kernel_top #(.AXI_Q_DEPTH(AXI_Q_DEPTH), .SQ_DEPTH(SQ_DEPTH)) i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout),
    .host_en   (host_en),
    .host_we   (host_we),
    .awaddr    (awaddr),
    .awsize    (awsize),
    .awburst   (awburst),
    .awid      (awid),
    .awlen     (awlen),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .wready    (wready),
    .bid       (bid),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  // slave model records accepted beats
  always @(posedge clk) begin
    if (rstn && awvalid && awready) begin
      if (aw_count < N_REC) begin
        got_awaddr[aw_count] <= awaddr;
        got_awsize[aw_count] <= awsize;
      end
      aw_count <= aw_count + 1;
      check_value("awburst", awburst, 2'd1);
      check_value("awid", awid, 4'd1);
      check_value("awlen", awlen, 8'd0);
    end
    if (rstn && wvalid && wready) begin
      if (w_count < N_REC) begin
        got_wdata[w_count] <= wdata;
        got_wstrb[w_count] <= wstrb;
      end
      w_count <= w_count + 1;
      check_value("wlast", wlast, 1'b1);
    end
  end

  task automatic apply_reset();
    @(posedge clk);
    rstn <= 1'b0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
  endtask

  task automatic host_write(input logic [HOST_ADDR_W-1:0] addr,
                            input logic [HOST_DATA_W-1:0] data);
    @(posedge clk);
    host_addr <= addr;
    host_din  <= data;
    host_we   <= 4'hF;
    host_en   <= 1'b1;
    @(posedge clk);
    host_en <= 1'b0;
    host_we <= 4'h0;
  endtask

  task automatic host_read(input logic [HOST_ADDR_W-1:0] addr,
                           output logic [HOST_DATA_W-1:0] data);
    @(posedge clk);
    host_addr <= addr;
    host_we   <= 4'h0;
    host_en   <= 1'b1;
    @(posedge clk);
    host_en <= 1'b0;
    @(negedge clk); // dout settled one cycle after the read
    data = host_dout;
  endtask

  task automatic read_check(input string name, input logic [HOST_ADDR_W-1:0] addr,
                            input logic [HOST_DATA_W-1:0] exp);
    logic [HOST_DATA_W-1:0] data;
    host_read(addr, data);
    check_value(name, data, exp);
  endtask

  task automatic fill_stage(input int n);
    for (int i = 0; i < n; i++) begin
      stage_words[i] = next_random();
      host_write(REG_STAGE0 + 15'(4 * i), stage_words[i]);
    end
  endtask

  task automatic wait_beats(input int n);
    int cycles;
    cycles = 0;
    while ((aw_count < n || w_count < n) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (aw_count < n || w_count < n) begin
      $display("timeout: slave saw %0d AW and %0d W beats, wanted %0d",
               aw_count, w_count, n);
      timeout_count++;
    end
  endtask

  task automatic send_response(input logic [AXI_ID_W-1:0] id,
                               input logic [AXI_RESP_W-1:0] resp);
    int cycles;
    @(posedge clk);
    bid    <= id;
    bresp  <= resp;
    bvalid <= 1'b1;
    cycles = 0;
    @(posedge clk);
    while (!bready && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    bvalid <= 1'b0;
    if (!bready) begin
      $display("timeout: the write response was never accepted");
      timeout_count++;
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check_value("awvalid", awvalid, 1'b0);
    check_value("wvalid", wvalid, 1'b0);
    check_value("bready", bready, 1'b1);
    check_value("host_dout", host_dout, 32'h0);
    read_check("sq pointers", REG_SQ_PTRS, 32'h0);
    read_check("b status", REG_B_STATUS, 32'h0);
  endtask

  task automatic check_stage_table();
    logic [31:0] word;
    for (int i = 0; i < 8; i++) begin
      word = next_random();
      stim_tbl[i] = {REG_STAGE0 + 15'(4 * i), word, word};
    end
    stim_tbl[8] = {REG_B_STATUS, 32'hFFFF_FFFF, 32'h0}; // read only
    stim_tbl[9] = {REG_SQ_PTRS, 32'h1234_5678, 32'h0};
    for (int i = 0; i < N_STIM; i++) begin
      host_write(stim_tbl[i].off, stim_tbl[i].data);
    end
    for (int i = 0; i < N_STIM; i++) begin
      read_check($sformatf("reg 0x%0h", stim_tbl[i].off), stim_tbl[i].off, stim_tbl[i].exp);
    end
  endtask

  task automatic check_write_path();
    for (int k = 0; k < N_BEATS; k++) begin
      fill_stage(3);
      exp_awaddr[k] = {stage_words[1], stage_words[0]};
      exp_awsize[k] = stage_words[2][2:0];
      host_write(REG_AW_PUSH, 32'h0);
      fill_stage(5);
      exp_wdata[k] = {stage_words[3], stage_words[2], stage_words[1], stage_words[0]};
      exp_wstrb[k] = stage_words[4][15:0];
      host_write(REG_W_PUSH, 32'h0);
    end
    @(negedge clk);
    check_value("awvalid held", awvalid, 1'b1);
    check_value("wvalid held", wvalid, 1'b1);
    @(posedge clk);
    awready <= 1'b1;
    wready  <= 1'b1;
    wait_beats(N_BEATS);
    repeat (2) @(negedge clk);
    check_value("aw beat count", aw_count, N_BEATS);
    check_value("w beat count", w_count, N_BEATS);
    for (int k = 0; k < N_BEATS; k++) begin
      check_value($sformatf("awaddr[%0d]", k), got_awaddr[k], exp_awaddr[k]);
      check_value($sformatf("awsize[%0d]", k), got_awsize[k], exp_awsize[k]);
      check_value($sformatf("wdata[%0d]", k), got_wdata[k], exp_wdata[k]);
      check_value($sformatf("wstrb[%0d]", k), got_wstrb[k], exp_wstrb[k]);
    end
  endtask

  task automatic check_response();
    send_response(4'h9, 2'b10);
    read_check("b status", REG_B_STATUS, 32'h1);
    host_write(REG_B_POP, 32'h0);
    read_check("stage0 after pop", REG_STAGE0, {26'h0, 4'h9, 2'b10}); // id above resp
    read_check("b status after pop", REG_B_STATUS, 32'h0);
  endtask

  task automatic check_command();
    logic [31:0] lba;
    logic [31:0] dptr;
    logic [31:0] ctrl;
    lba  = next_random();
    dptr = next_random();
    ctrl = next_random();
    host_write(REG_CMD_LBA, lba);
    host_write(REG_CMD_DPTR, dptr);
    host_write(REG_CMD_CTRL, ctrl);
    host_write(REG_SQ_DOORBELL, 32'h0);
    read_check("sq pointers", REG_SQ_PTRS, {16'd1, 16'd1});
    read_check("entry cdw0", REG_SQ_ENTRY + 15'h00, {16'd0, 8'h00, ctrl[7:0]});
    read_check("entry nsid", REG_SQ_ENTRY + 15'h04, 32'd1);
    read_check("entry dptr", REG_SQ_ENTRY + 15'h18, dptr);
    read_check("entry lba", REG_SQ_ENTRY + 15'h28, {ctrl[31:16], lba[15:0]});
    read_check("doorbell read", REG_SQ_DOORBELL, {16'd0, 8'h00, ctrl[7:0]});
  endtask

  task automatic check_queue_full();
    apply_reset();
    for (int i = 0; i <= SQ_DEPTH; i++) begin
      host_write(REG_CMD_CTRL, 32'h0000_0002); // nvme read opcode
      host_write(REG_SQ_DOORBELL, 32'h0);
    end
    read_check("sq pointers full", REG_SQ_PTRS, {16'(SQ_DEPTH), 16'(SQ_DEPTH)});
    for (int i = 0; i < SQ_DEPTH; i++) begin
      read_check($sformatf("pop %0d", i), REG_SQ_DOORBELL, {16'(i), 8'h00, 8'h02});
    end
    read_check("sq pointers after pops", REG_SQ_PTRS, {16'(SQ_DEPTH), 16'(SQ_DEPTH)});
  endtask

  initial begin
    rstn           = 1'b0;
    host_addr      = '0;
    host_din       = '0;
    host_en        = 1'b0;
    host_we        = 4'h0;
    awready        = 1'b0;
    wready         = 1'b0;
    bvalid         = 1'b0;
    bid            = '0;
    bresp          = '0;
    mismatch_count = 0;
    timeout_count  = 0;
    lcg_state      = 32'h7802;

    apply_reset();
    check_reset_state();
    check_stage_table();
    check_write_path();
    check_response();
    check_command();
    check_queue_full();

    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
